//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_XLEN 32

// first fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_0000

// program counter step
`define CPU_INSTR_LEN 32'd4

// the bus is 8 bits wide, so a word is four transfers
`define CPU_WORD_BYTES 4

// x0..x31
`define CPU_NUM_REGS 32

`endif

//--- cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;

    // major opcodes, encoded as instr[6:2]
    typedef enum logic [4:0] {
        opc_load     = 5'b00000,
        opc_misc_mem = 5'b00011,
        opc_op_imm   = 5'b00100,
        opc_auipc    = 5'b00101,
        opc_store    = 5'b01000,
        opc_op       = 5'b01100,
        opc_lui      = 5'b01101,
        opc_branch   = 5'b11000,
        opc_jalr     = 5'b11001,
        opc_jal      = 5'b11011,
        opc_system   = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        st_reset,
        st_fetch,
        st_decode,
        st_exec,
        st_load2,
        st_store2,
        st_branch2
    } state_t;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        word_t      imm;
        opcode_t    opcode;
        logic [2:0] funct3;
        // funct7 bit 5, selects sub and sra
        logic       alt;
        // {geu, ltu, ge, lt, ne, eq}
        logic [5:0] branch_mask;
    } dec_t;

    typedef struct packed {
        word_t      adr;
        logic [7:0] dat;
        logic       cyc;
        logic       stb;
        logic       we;
    } wb_req_t;

    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
        logic       stall;
    } wb_rsp_t;

endpackage

//--- cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  logic              clk,
    input  logic              en,
    input  cpu_pkg::alu_op_t  op,
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    output cpu_pkg::word_t    result,
    output logic              lt,
    output logic              ltu,
    output logic              eq
);

    logic slt_w;
    logic sltu_w;

    assign slt_w  = $signed(a) < $signed(b);
    assign sltu_w = a < b;

    // outputs hold between enables
    always_ff @(posedge clk) begin
        if (en) begin
            lt  <= slt_w;
            ltu <= sltu_w;
            eq  <= (a == b);
            case (op)
                cpu_pkg::alu_add:  result <= a + b;
                cpu_pkg::alu_sub:  result <= a - b;
                cpu_pkg::alu_sll:  result <= a << b[4:0];
                cpu_pkg::alu_slt:  result <= cpu_pkg::word_t'(slt_w);
                cpu_pkg::alu_sltu: result <= cpu_pkg::word_t'(sltu_w);
                cpu_pkg::alu_xor:  result <= a ^ b;
                cpu_pkg::alu_srl:  result <= a >> b[4:0];
                // arithmetic shift keeps the sign bit
                cpu_pkg::alu_sra:  result <= $signed(a) >>> b[4:0];
                cpu_pkg::alu_or:   result <= a | b;
                cpu_pkg::alu_and:  result <= a & b;
                default:           result <= a + b;
            endcase
        end
    end

endmodule

//--- cpu_decoder.sv
`timescale 1ns/1ps

module cpu_decoder (
    input  logic            clk,
    input  logic            en,
    input  cpu_pkg::word_t  instr,
    output cpu_pkg::dec_t   dec
);

    cpu_pkg::opcode_t opc;
    cpu_pkg::word_t   imm;
    logic [5:0]       mask;

    assign opc = cpu_pkg::opcode_t'(instr[6:2]);

    // immediate format follows the opcode
    always_comb begin
        case (opc)
            cpu_pkg::opc_lui,
            cpu_pkg::opc_auipc:  imm = {instr[31:12], 12'b0};
            cpu_pkg::opc_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20],
                                        instr[30:21], 1'b0};
            cpu_pkg::opc_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25],
                                        instr[11:8], 1'b0};
            cpu_pkg::opc_store:  imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            // I format for op_imm, load, jalr and the rest
            default:             imm = {{21{instr[31]}}, instr[30:20]};
        endcase
    end

    // one-hot branch condition, matched against the ALU flags by control
    always_comb begin
        case (instr[14:12])
            3'b000:  mask = 6'b000001;
            3'b001:  mask = 6'b000010;
            3'b100:  mask = 6'b000100;
            3'b101:  mask = 6'b001000;
            3'b110:  mask = 6'b010000;
            3'b111:  mask = 6'b100000;
            default: mask = 6'b000000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            dec.rs1         <= instr[19:15];
            dec.rs2         <= instr[24:20];
            dec.rd          <= instr[11:7];
            dec.imm         <= imm;
            dec.opcode      <= opc;
            dec.funct3      <= instr[14:12];
            dec.alt         <= instr[30];
            dec.branch_mask <= mask;
        end
    end

endmodule

//--- cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile (
    input  logic            clk,
    input  logic            re,
    input  logic            we,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  cpu_pkg::word_t  wdata,
    output cpu_pkg::word_t  rdata1,
    output cpu_pkg::word_t  rdata2
);

    // x0 has no storage
    cpu_pkg::word_t regs [1:`CPU_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
        if (re) begin
            rdata1 <= (rs1 == 5'd0) ? '0 : regs[rs1];
            rdata2 <= (rs2 == 5'd0) ? '0 : regs[rs2];
        end
    end

endmodule

//--- wb8_master.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module wb8_master (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              write,
    input  cpu_pkg::word_t    addr,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata,
    output logic              done,
    output cpu_pkg::wb_req_t  wb_req,
    input  cpu_pkg::wb_rsp_t  wb_rsp
);

    localparam int CNT_W = $clog2(`CPU_WORD_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`CPU_WORD_BYTES - 1);

    typedef enum logic [1:0] {
        bus_idle,
        bus_strobe,
        bus_ack
    } bus_state_t;

    bus_state_t       state;
    logic [CNT_W-1:0] cnt;
    cpu_pkg::word_t   base;
    cpu_pkg::word_t   wbuf;
    logic             we_q;

    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (reset) begin
            state <= bus_idle;
            cnt   <= '0;
        end else begin
            case (state)
                bus_idle: begin
                    if (start) begin
                        base  <= addr;
                        wbuf  <= wdata;
                        we_q  <= write;
                        cnt   <= '0;
                        state <= bus_strobe;
                    end
                end
                // byte taken when stall is low
                bus_strobe: begin
                    if (!wb_rsp.stall) begin
                        state <= bus_ack;
                    end
                end
                bus_ack: begin
                    if (wb_rsp.ack) begin
                        if (!we_q) begin
                            rdata[cnt*8 +: 8] <= wb_rsp.dat;
                        end
                        if (cnt == LAST_BYTE) begin
                            done  <= 1'b1;
                            state <= bus_idle;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= bus_strobe;
                        end
                    end
                end
                default: state <= bus_idle;
            endcase
        end
    end

    // little-endian, lowest address first
    always_comb begin
        wb_req.cyc = (state != bus_idle);
        wb_req.stb = (state == bus_strobe);
        wb_req.we  = we_q && (state != bus_idle);
        wb_req.adr = base + cpu_pkg::word_t'(cnt);
        wb_req.dat = wbuf[cnt*8 +: 8];
    end

endmodule

//--- cpu_control.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_control (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::dec_t     dec,
    input  cpu_pkg::word_t    alu_result,
    input  logic              alu_lt,
    input  logic              alu_ltu,
    input  logic              alu_eq,
    input  cpu_pkg::word_t    reg_rdata1,
    input  cpu_pkg::word_t    reg_rdata2,
    input  cpu_pkg::word_t    bus_rdata,
    input  logic              bus_done,
    output logic              alu_en,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::word_t    alu_a,
    output cpu_pkg::word_t    alu_b,
    output logic              dec_en,
    output logic              reg_re,
    output logic              reg_we,
    output cpu_pkg::word_t    reg_wdata,
    output logic              bus_start,
    output logic              bus_write,
    output cpu_pkg::word_t    bus_addr
);

    cpu_pkg::state_t  state;
    cpu_pkg::word_t   pc;
    cpu_pkg::word_t   pcnext;
    cpu_pkg::word_t   fetch_addr;
    cpu_pkg::alu_op_t arith_op;
    logic             nextpc_from_alu;
    logic             wb_alu;
    logic             wb_bus;
    logic             bus_wait;
    logic             branch_taken;

    // jump targets come from the ALU, bit 0 cleared for jalr
    assign fetch_addr = nextpc_from_alu ? {alu_result[31:1], 1'b0} : pcnext;

    assign branch_taken = |(dec.branch_mask &
                            {!alu_ltu, alu_ltu, !alu_lt, alu_lt, !alu_eq, alu_eq});

    // funct3 to ALU operation, shared by op and op_imm
    always_comb begin
        case (dec.funct3)
            3'b000:  arith_op = (dec.alt && dec.opcode == cpu_pkg::opc_op) ?
                                cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001:  arith_op = cpu_pkg::alu_sll;
            3'b010:  arith_op = cpu_pkg::alu_slt;
            3'b011:  arith_op = cpu_pkg::alu_sltu;
            3'b100:  arith_op = cpu_pkg::alu_xor;
            3'b101:  arith_op = dec.alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110:  arith_op = cpu_pkg::alu_or;
            default: arith_op = cpu_pkg::alu_and;
        endcase
    end

    always_comb begin
        alu_en    = 1'b0;
        alu_op    = cpu_pkg::alu_add;
        alu_a     = reg_rdata1;
        alu_b     = reg_rdata2;
        dec_en    = 1'b0;
        reg_re    = 1'b0;
        reg_we    = 1'b0;
        reg_wdata = alu_result;
        bus_start = 1'b0;
        bus_write = 1'b0;
        bus_addr  = alu_result;
        case (state)
            cpu_pkg::st_fetch: begin
                // previous instruction retires as the fetch starts
                reg_we    = !bus_wait && (wb_alu || wb_bus);
                reg_wdata = wb_bus ? bus_rdata : alu_result;
                bus_start = !bus_wait;
                bus_addr  = fetch_addr;
                dec_en    = bus_done;
            end
            cpu_pkg::st_decode: begin
                // idle ALU computes pc + 4
                reg_re = 1'b1;
                alu_en = 1'b1;
                alu_a  = pc;
                alu_b  = `CPU_INSTR_LEN;
            end
            cpu_pkg::st_exec: begin
                case (dec.opcode)
                    cpu_pkg::opc_op: begin
                        alu_en = 1'b1;
                        alu_op = arith_op;
                    end
                    cpu_pkg::opc_op_imm: begin
                        alu_en = 1'b1;
                        alu_op = arith_op;
                        alu_b  = dec.imm;
                    end
                    cpu_pkg::opc_load,
                    cpu_pkg::opc_store: begin
                        alu_en = 1'b1;
                        alu_b  = dec.imm;
                    end
                    cpu_pkg::opc_jal,
                    cpu_pkg::opc_jalr: begin
                        // link value is the pc + 4 left by decode
                        reg_we = 1'b1;
                        alu_en = 1'b1;
                        alu_b  = dec.imm;
                        if (dec.opcode == cpu_pkg::opc_jal) begin
                            alu_a = pc;
                        end
                    end
                    // compare only, flags used in branch2
                    cpu_pkg::opc_branch: alu_en = 1'b1;
                    cpu_pkg::opc_auipc: begin
                        alu_en = 1'b1;
                        alu_a  = pc;
                        alu_b  = dec.imm;
                    end
                    cpu_pkg::opc_lui: begin
                        reg_we    = 1'b1;
                        reg_wdata = dec.imm;
                    end
                    default: ;
                endcase
            end
            cpu_pkg::st_load2: bus_start = !bus_wait;
            cpu_pkg::st_store2: begin
                bus_start = !bus_wait;
                bus_write = 1'b1;
            end
            cpu_pkg::st_branch2: begin
                // branch target, used only if taken
                alu_en = 1'b1;
                alu_a  = pc;
                alu_b  = dec.imm;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= cpu_pkg::st_reset;
            bus_wait        <= 1'b0;
            wb_alu          <= 1'b0;
            wb_bus          <= 1'b0;
            nextpc_from_alu <= 1'b0;
        end else begin
            if (bus_start) begin
                bus_wait <= 1'b1;
            end else if (bus_done) begin
                bus_wait <= 1'b0;
            end
            case (state)
                cpu_pkg::st_reset: begin
                    pcnext <= `CPU_RESET_VECTOR;
                    state  <= cpu_pkg::st_fetch;
                end
                cpu_pkg::st_fetch: begin
                    if (!bus_wait) begin
                        pc     <= fetch_addr;
                        wb_alu <= 1'b0;
                        wb_bus <= 1'b0;
                    end else if (bus_done) begin
                        state <= cpu_pkg::st_decode;
                    end
                end
                cpu_pkg::st_decode: begin
                    nextpc_from_alu <= 1'b0;
                    state           <= cpu_pkg::st_exec;
                end
                cpu_pkg::st_exec: begin
                    pcnext <= alu_result;
                    state  <= cpu_pkg::st_fetch;
                    case (dec.opcode)
                        cpu_pkg::opc_op,
                        cpu_pkg::opc_op_imm,
                        cpu_pkg::opc_auipc:  wb_alu <= 1'b1;
                        cpu_pkg::opc_load:   state <= cpu_pkg::st_load2;
                        cpu_pkg::opc_store:  state <= cpu_pkg::st_store2;
                        cpu_pkg::opc_branch: state <= cpu_pkg::st_branch2;
                        cpu_pkg::opc_jal,
                        cpu_pkg::opc_jalr:   nextpc_from_alu <= 1'b1;
                        // misc_mem, system and unknown opcodes retire as no-ops
                        default: ;
                    endcase
                end
                cpu_pkg::st_load2: begin
                    if (bus_done) begin
                        wb_bus <= 1'b1;
                        state  <= cpu_pkg::st_fetch;
                    end
                end
                cpu_pkg::st_store2: begin
                    if (bus_done) begin
                        state <= cpu_pkg::st_fetch;
                    end
                end
                cpu_pkg::st_branch2: begin
                    nextpc_from_alu <= branch_taken;
                    state           <= cpu_pkg::st_fetch;
                end
                default: state <= cpu_pkg::st_reset;
            endcase
        end
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    output cpu_pkg::wb_req_t  wb_req,
    input  cpu_pkg::wb_rsp_t  wb_rsp
);

    cpu_pkg::dec_t    dec;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::word_t   alu_a;
    cpu_pkg::word_t   alu_b;
    cpu_pkg::word_t   alu_result;
    cpu_pkg::word_t   reg_rdata1;
    cpu_pkg::word_t   reg_rdata2;
    cpu_pkg::word_t   reg_wdata;
    cpu_pkg::word_t   bus_rdata;
    cpu_pkg::word_t   bus_addr;
    logic             alu_en;
    logic             alu_lt;
    logic             alu_ltu;
    logic             alu_eq;
    logic             dec_en;
    logic             reg_re;
    logic             reg_we;
    logic             bus_start;
    logic             bus_write;
    logic             bus_done;

    cpu_control u_control (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .alu_result (alu_result),
        .alu_lt     (alu_lt),
        .alu_ltu    (alu_ltu),
        .alu_eq     (alu_eq),
        .reg_rdata1 (reg_rdata1),
        .reg_rdata2 (reg_rdata2),
        .bus_rdata  (bus_rdata),
        .bus_done   (bus_done),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .dec_en     (dec_en),
        .reg_re     (reg_re),
        .reg_we     (reg_we),
        .reg_wdata  (reg_wdata),
        .bus_start  (bus_start),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr)
    );

    cpu_alu u_alu (
        .clk    (clk),
        .en     (alu_en),
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .lt     (alu_lt),
        .ltu    (alu_ltu),
        .eq     (alu_eq)
    );

    // the fetched word is decoded straight from the bus master
    cpu_decoder u_dec (
        .clk   (clk),
        .en    (dec_en),
        .instr (bus_rdata),
        .dec   (dec)
    );

    cpu_regfile u_regs (
        .clk    (clk),
        .re     (reg_re),
        .we     (reg_we),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .wdata  (reg_wdata),
        .rdata1 (reg_rdata1),
        .rdata2 (reg_rdata2)
    );

    // store data is read port 2
    wb8_master u_bus (
        .clk    (clk),
        .reset  (reset),
        .start  (bus_start),
        .write  (bus_write),
        .addr   (bus_addr),
        .wdata  (reg_rdata2),
        .rdata  (bus_rdata),
        .done   (bus_done),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

//--- cpu_props.sv
`timescale 1ns/1ps

module cpu_props (
    input logic              clk,
    input logic              reset,
    input cpu_pkg::wb_req_t  wb_req,
    input cpu_pkg::wb_rsp_t  wb_rsp
);

    // set between an accepted byte and its ack
    logic waiting;

    always_ff @(posedge clk) begin
        if (reset) begin
            waiting <= 1'b0;
        end else if (wb_req.stb && !wb_rsp.stall) begin
            waiting <= 1'b1;
        end else if (wb_rsp.ack) begin
            waiting <= 1'b0;
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc)
        else $error("stb without cyc");

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && wb_rsp.stall |=> wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we))
        else $error("request changed under stall");

    a_no_strobe: assert property (@(posedge clk) disable iff (reset)
        waiting |-> !wb_req.stb)
        else $error("strobe before ack");

    a_reset_cyc: assert property (@(posedge clk)
        reset |=> !wb_req.cyc)
        else $error("cyc high after reset");

endmodule

//--- cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    logic               clk;
    logic               reset;
    cpu_pkg::wb_req_t   wb_req;
    cpu_pkg::wb_rsp_t   wb_rsp;

    logic [7:0]         mem [0:4095];
    integer             seed;
    bit                 mem_pending;
    int                 mem_delay;
    cpu_pkg::word_t     mem_addr;

    cpu_pkg::word_t     exp_addr[$];
    cpu_pkg::word_t     exp_data[$];
    int                 exp_tag[$];
    string              test_name[6];
    int                 test_stores[6];
    int                 test_errs[6];
    int                 cur_tag;
    int                 errors;
    int                 checks;
    bit                 timed_out;
    int                 pc_b;
    int                 dp;

    int                 nbytes;
    cpu_pkg::word_t     sbase;
    cpu_pkg::word_t     sdata;
    int                 tag;

    cpu_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    bind wb8_master cpu_props u_props (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #20 clk = ~clk;

    // byte memory with random stall and ack latency
    always @(posedge clk) begin
        wb_rsp.ack   <= 1'b0;
        wb_rsp.stall <= ($random(seed) & 3) == 0;
        if (mem_pending) begin
            if (mem_delay == 0) begin
                wb_rsp.ack  <= 1'b1;
                wb_rsp.dat  <= mem[mem_addr[11:0]];
                mem_pending = 1'b0;
            end else begin
                mem_delay = mem_delay - 1;
            end
        end else if (wb_req.cyc && wb_req.stb && !wb_rsp.stall) begin
            mem_pending = 1'b1;
            mem_delay   = $random(seed) & 3;
            mem_addr    = wb_req.adr;
            if (wb_req.we) begin
                mem[wb_req.adr[11:0]] = wb_req.dat;
            end
        end
    end

    function automatic cpu_pkg::word_t alu_ref(cpu_pkg::alu_op_t op, cpu_pkg::word_t a,
                                               cpu_pkg::word_t b);
        int sh;
        sh = b[4:0];
        case (op)
            cpu_pkg::alu_add:  return a + b;
            cpu_pkg::alu_sub:  return a + ~b + 1;
            cpu_pkg::alu_sll:  return a << sh;
            cpu_pkg::alu_slt:  return (a[31] != b[31]) ? a[31] : (a < b);
            cpu_pkg::alu_sltu: return (a < b) ? 1 : 0;
            cpu_pkg::alu_xor:  return a ^ b;
            cpu_pkg::alu_srl:  return a >> sh;
            // fill the vacated top bits with the sign
            cpu_pkg::alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 0);
            cpu_pkg::alu_or:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    function automatic bit branch_ref(logic [2:0] f3, cpu_pkg::word_t a, cpu_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // {alt, funct3} of each operation
    function automatic logic [3:0] op_funct(cpu_pkg::alu_op_t op);
        case (op)
            cpu_pkg::alu_add:  return 4'b0000;
            cpu_pkg::alu_sub:  return 4'b1000;
            cpu_pkg::alu_sll:  return 4'b0001;
            cpu_pkg::alu_slt:  return 4'b0010;
            cpu_pkg::alu_sltu: return 4'b0011;
            cpu_pkg::alu_xor:  return 4'b0100;
            cpu_pkg::alu_srl:  return 4'b0101;
            cpu_pkg::alu_sra:  return 4'b1101;
            cpu_pkg::alu_or:   return 4'b0110;
            default:           return 4'b0111;
        endcase
    endfunction

    task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs[cur_tag]++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // adr only matters while a strobe is expected
    task automatic check_req(string name, cpu_pkg::wb_req_t got, cpu_pkg::wb_req_t exp);
        checks++;
        if ({got.cyc, got.stb, got.we} !== {exp.cyc, exp.stb, exp.we} ||
            (exp.stb && got.adr !== exp.adr)) begin
            errors++;
            test_errs[cur_tag]++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic emit(cpu_pkg::word_t w);
        mem[pc_b]     = w[7:0];
        mem[pc_b + 1] = w[15:8];
        mem[pc_b + 2] = w[23:16];
        mem[pc_b + 3] = w[31:24];
        pc_b += 4;
    endtask

    function automatic cpu_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_pkg::word_t enc_s(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic cpu_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic cpu_pkg::word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_const(logic [4:0] rd, cpu_pkg::word_t val);
        cpu_pkg::word_t hi;
        hi = (val + 32'h800) >> 12;
        emit({hi[19:0], rd, 7'b0110111});
        emit(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic store_expect(int t, logic [4:0] rs, cpu_pkg::word_t val);
        emit(enc_s(dp[11:0], rs));
        exp_addr.push_back(dp);
        exp_data.push_back(val);
        exp_tag.push_back(t);
        dp += 4;
    endtask

    task automatic build_program();
        cpu_pkg::alu_op_t op;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        logic [11:0]      imm;
        logic [3:0]       fn;
        logic [2:0]       f3s [6];
        int               p;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int k = 0; k < 10; k++) begin
            op = cpu_pkg::alu_op_t'(k);
            a  = $random(seed);
            b  = $random(seed);
            fn = op_funct(op);
            load_const(1, a);
            load_const(2, b);
            emit({1'b0, fn[3], 5'd0, 5'd2, 5'd1, fn[2:0], 5'd5, 7'b0110011});
            store_expect(1, 5, alu_ref(op, a, b));
        end
        for (int k = 0; k < 10; k++) begin
            op = cpu_pkg::alu_op_t'(k);
            if (op == cpu_pkg::alu_sub) continue;
            a   = $random(seed);
            imm = 12'($random(seed));
            fn  = op_funct(op);
            if (fn[1:0] == 2'b01) begin
                // shifts carry shamt and the alt bit
                imm = {1'b0, fn[3], 5'd0, imm[4:0]};
                b   = imm[4:0];
            end else begin
                b = {{20{imm[11]}}, imm};
            end
            load_const(1, a);
            emit(enc_i(imm, 1, fn[2:0], 5, 7'b0010011));
            store_expect(2, 5, alu_ref(op, a, b));
        end
        a = $random(seed);
        emit({a[19:0], 5'd5, 7'b0110111});
        store_expect(2, 5, {a[19:0], 12'b0});
        p = pc_b;
        emit({a[31:12], 5'd5, 7'b0010111});
        store_expect(2, 5, alu_ref(cpu_pkg::alu_add, p, {a[31:12], 12'b0}));
        load_const(6, 32'h7a7e_0001);
        load_const(7, 32'h7a7e_0002);
        for (int k = 0; k < 6; k++) begin
            a = $random(seed);
            b = ($random(seed) & 1) ? a : $random(seed);
            load_const(1, a);
            load_const(2, b);
            emit(enc_b(13'd12, 2, 1, f3s[k]));
            emit(enc_s(dp[11:0], 7));
            emit(enc_j(21'd8, 0));
            emit(enc_s(dp[11:0], 6));
            exp_addr.push_back(dp);
            exp_data.push_back(branch_ref(f3s[k], a, b) ? 32'h7a7e_0001 : 32'h7a7e_0002);
            exp_tag.push_back(3);
            dp += 4;
        end
        // the skipped stores must never reach the bus
        p = pc_b;
        emit(enc_j(21'd8, 3));
        emit(enc_s(12'h7fc, 0));
        store_expect(4, 3, p + 4);
        load_const(4, pc_b + 16);
        p = pc_b;
        emit(enc_i(12'd0, 4, 3'b000, 3, 7'b1100111));
        emit(enc_s(12'h7fc, 0));
        store_expect(4, 3, p + 4);
        for (int k = 0; k < 3; k++) begin
            a = $random(seed);
            load_const(8, a);
            p = dp;
            store_expect(5, 8, a);
            emit(enc_i(p[11:0], 0, 3'b010, 9, 7'b0000011));
            store_expect(5, 9, a);
        end
        emit(enc_j(21'd0, 0));
    endtask

    // pairs each bus word with the next expected store
    always @(negedge clk) begin
        if (!wb_req.cyc) begin
            nbytes = 0;
        end else if (wb_req.stb && wb_req.we && !wb_rsp.stall) begin
            if (nbytes == 0) begin
                sbase = wb_req.adr;
                if (exp_tag.size() > 0) cur_tag = exp_tag[0];
            end else begin
                check_word("wb_req.adr", wb_req.adr, sbase + nbytes);
            end
            sdata[nbytes*8 +: 8] = wb_req.dat;
            nbytes++;
            if (nbytes == `CPU_WORD_BYTES) begin
                nbytes = 0;
                if (exp_tag.size() == 0) begin
                    errors++;
                    $display("unexpected store of %h at address %h", sdata, sbase);
                end else begin
                    tag = exp_tag.pop_front();
                    check_word("store address", sbase, exp_addr.pop_front());
                    check_word("store data", sdata, exp_data.pop_front());
                    test_stores[tag]++;
                    if (exp_tag.size() == 0 || exp_tag[0] != tag) begin
                        $display("test %0d %s: %0d stores, %0d errors", tag, test_name[tag],
                                 test_stores[tag], test_errs[tag]);
                    end
                end
            end
        end
    end

    task automatic wait_strobe(string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(wb_req.stb && !wb_rsp.stall) && n < 1000);
        if (n >= 1000) begin
            timed_out = 1'b1;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic wait_stores();
        int n;
        n = 0;
        while (exp_tag.size() > 0 && n < 200000) begin
            @(negedge clk);
            n++;
        end
        if (exp_tag.size() > 0) begin
            timed_out = 1'b1;
            $display("timeout with %0d expected stores still missing", exp_tag.size());
        end
    endtask

    initial begin
        cpu_pkg::wb_req_t exp;
        clk    = 1'b0;
        reset  = 1'b1;
        wb_rsp = '0;
        seed   = 17467;
        test_name = '{"reset", "reg ops", "imm ops", "branches", "jumps", "load store"};
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ 8'h5a);
        end
        pc_b = `CPU_RESET_VECTOR;
        dp   = 'h700;
        build_program();
        cur_tag = 0;
        exp     = '0;
        // bus outputs settle on the first reset edge
        @(posedge clk);
        repeat (7) begin
            @(negedge clk);
            check_req("wb_req", wb_req, exp);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_req("wb_req", wb_req, exp);
        for (int i = 0; i < `CPU_WORD_BYTES; i++) begin
            if (!timed_out) begin
                wait_strobe("the first fetch");
                exp.adr = `CPU_RESET_VECTOR + i;
                exp.cyc = 1'b1;
                exp.stb = 1'b1;
                check_req("wb_req", wb_req, exp);
            end
        end
        $display("test 0 %s: %0d errors", test_name[0], test_errs[0]);
        if (!timed_out) begin
            wait_stores();
        end
        repeat (100) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_decoder.sv
cpu_regfile.sv
wb8_master.sv
cpu_control.sv
cpu_top.sv
cpu_props.sv
cpu_tb.sv

//--- Makefile
TOP       ?= cpu_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build output and the log"
	@echo "  help   list the targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
